/* rtl/dtcore32_pkg.sv */
package dtcore32_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int OPCODE_W   = 7;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;

  // funct3 of ECALL/EBREAK/xRET inside the SYSTEM opcode
  localparam logic [FUNCT3_W-1:0] FUNCT3_PRIV = 3'b000;

  // forwarding mux select for an EX operand
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_WB   = 2'b01,
    FWD_MEM  = 2'b10
  } fwd_sel_e;

  // RV32I major opcodes the decoder knows about
  typedef enum logic [OPCODE_W-1:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    SYSTEM = 7'b1110011
  } opcode_e;

  typedef struct packed {
    logic [FUNCT7_W-1:0]   funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [FUNCT3_W-1:0]   funct3;
    logic [REG_ADDR_W-1:0] rd;
    opcode_e               opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [FUNCT3_W-1:0]   funct3;
    logic [4:0]            imm_lo;
    opcode_e               opcode;
  } s_fmt_t;

  // same 32-bit word, seen as R-type or as S-type
  typedef union packed {
    r_fmt_t r_fmt;
    s_fmt_t s_fmt;
  } instr_u;

  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] src1;
    logic [REG_ADDR_W-1:0] src2;
    logic [REG_ADDR_W-1:0] dest;
    logic                  reg_wr_en;
    logic                  dmem_read;
    logic                  trap_valid;
  } stage_meta_t;

  localparam stage_meta_t META_BUBBLE = '0;

  typedef struct packed {
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     if_stall;
    logic     id_stall;
    logic     ex_stall;
    logic     mem_stall;
    logic     id_flush;
    logic     ex_flush;
  } hazard_ctrl_t;

endpackage

/* rtl/dtcore32_decode_fields.sv */
`timescale 1ns/1ps

module dtcore32_decode_fields
  import dtcore32_pkg::*;
(
  input  instr_u      instr_i,
  input  logic        valid_i,
  output stage_meta_t meta_o
);

  logic                  reads_rs1;
  logic                  reads_rs2;
  logic                  writes_rd;
  logic                  trap;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;

  // register usage per major opcode
  always_comb
  begin
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    writes_rd = 1'b0;
    trap      = 1'b0;
    case (instr_i.r_fmt.opcode)
      OP:
      begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
        writes_rd = 1'b1;
      end
      OP_IMM, LOAD, JALR:
      begin
        reads_rs1 = 1'b1;
        writes_rd = 1'b1;
      end
      STORE, BRANCH:
      begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      JAL, LUI, AUIPC:
        writes_rd = 1'b1;
      SYSTEM:
      begin
        if (instr_i.r_fmt.funct3 == FUNCT3_PRIV)
          trap = 1'b1;
        else
        begin
          // CSR ops, the immediate forms carry a zimm in the rs1 slot
          reads_rs1 = ~instr_i.r_fmt.funct3[2];
          writes_rd = 1'b1;
        end
      end
      default:
        trap = 1'b1;
    endcase
  end

  // sources sit at the same bits in every layout, rd only in R
  assign rs1 = instr_i.s_fmt.rs1;
  assign rs2 = instr_i.s_fmt.rs2;
  assign rd  = instr_i.r_fmt.rd;

  always_comb
  begin
    meta_o = META_BUBBLE;
    if (valid_i)
    begin
      meta_o.valid      = 1'b1;
      meta_o.src1       = reads_rs1 ? rs1 : '0;
      meta_o.src2       = reads_rs2 ? rs2 : '0;
      meta_o.dest       = writes_rd ? rd : '0;
      meta_o.reg_wr_en  = writes_rd && (rd != '0);
      meta_o.dmem_read  = (instr_i.r_fmt.opcode == LOAD);
      meta_o.trap_valid = trap;
    end
  end

endmodule

/* rtl/dtcore32_hazard_unit.sv */
`timescale 1ns/1ps

module dtcore32_hazard_unit
  import dtcore32_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  stage_meta_t  id_meta_i,
  input  stage_meta_t  ex_meta_i,
  input  stage_meta_t  mem_meta_i,
  input  stage_meta_t  wb_meta_i,
  input  logic         pc_src_i,
  output hazard_ctrl_t ctrl_o
);

  logic dmem_stall_q;
  logic load_use;
  logic pc_src;
  logic later_trap;

  // MEM result is younger than WB, so it wins when both write the source
  function automatic fwd_sel_e fwd_select(input logic [REG_ADDR_W-1:0] src,
                                          input stage_meta_t mem_meta,
                                          input stage_meta_t wb_meta);
    fwd_sel_e sel;
    sel = FWD_NONE;
    if (src != '0)
    begin
      if (mem_meta.reg_wr_en && (mem_meta.dest == src))
        sel = FWD_MEM;
      else if (wb_meta.reg_wr_en && (wb_meta.dest == src))
        sel = FWD_WB;
    end
    return sel;
  endfunction

  // one cycle of freeze for the data memory read, then let go
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      dmem_stall_q <= 1'b0;
    else if (dmem_stall_q)
      dmem_stall_q <= 1'b0;
    else
      dmem_stall_q <= ex_meta_i.dmem_read;
  end

  // load in EX whose result the instruction in ID still needs
  assign load_use = ex_meta_i.dmem_read
                    && (ex_meta_i.dest != '0)
                    && ((id_meta_i.src1 == ex_meta_i.dest)
                        || (id_meta_i.src2 == ex_meta_i.dest));

  // branch outcome only counts for a real instruction in EX
  assign pc_src = pc_src_i && ex_meta_i.valid;

  assign later_trap = mem_meta_i.trap_valid || wb_meta_i.trap_valid;

  always_comb
  begin
    ctrl_o.fwd_a     = fwd_select(ex_meta_i.src1, mem_meta_i, wb_meta_i);
    ctrl_o.fwd_b     = fwd_select(ex_meta_i.src2, mem_meta_i, wb_meta_i);
    ctrl_o.if_stall  = load_use || dmem_stall_q;
    ctrl_o.id_stall  = load_use || dmem_stall_q;
    ctrl_o.ex_stall  = dmem_stall_q;
    ctrl_o.mem_stall = dmem_stall_q;
    // a trap still in EX must not kill itself, so it only clears ID
    ctrl_o.id_flush  = pc_src || ex_meta_i.trap_valid || later_trap;
    ctrl_o.ex_flush  = pc_src || later_trap;
  end

  // the stall keeps the load in MEM while its read completes
  a_dmem_stall_holds_load : assert property (
    @(posedge clk_i) disable iff (rst_i)
    dmem_stall_q |-> mem_meta_i.dmem_read
  );

  // a bubble in MEM never feeds an operand
  a_fwd_mem_valid : assert property (
    @(posedge clk_i) disable iff (rst_i)
    ((ctrl_o.fwd_a == FWD_MEM) || (ctrl_o.fwd_b == FWD_MEM)) |-> mem_meta_i.valid
  );

endmodule

/* rtl/dtcore32_stage_regs.sv */
`timescale 1ns/1ps

module dtcore32_stage_regs
  import dtcore32_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  instr_u       instr_i,
  input  logic         instr_valid_i,
  input  hazard_ctrl_t ctrl_i,
  input  stage_meta_t  id_meta_i,
  output instr_u       id_instr_o,
  output logic         id_valid_o,
  output stage_meta_t  ex_meta_o,
  output stage_meta_t  mem_meta_o,
  output stage_meta_t  wb_meta_o
);

  instr_u      id_instr_q;
  logic        id_valid_q;
  stage_meta_t ex_meta_q;
  stage_meta_t mem_meta_q;
  stage_meta_t wb_meta_q;

  // IF/ID word, only meaningful while id_valid_q is set
  always_ff @(posedge clk_i)
  begin
    if (!ctrl_i.id_stall)
      id_instr_q <= instr_i;
  end

  // flush beats the load-use hold
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      id_valid_q <= 1'b0;
    else if (ctrl_i.id_flush)
      id_valid_q <= 1'b0;
    else if (!ctrl_i.id_stall)
      id_valid_q <= instr_valid_i;
  end

  // ID/EX
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      ex_meta_q <= META_BUBBLE;
    else if (ctrl_i.ex_flush)
      ex_meta_q <= META_BUBBLE;
    else if (!ctrl_i.ex_stall)
    begin
      // ID held for load-use, so EX gets a bubble
      if (ctrl_i.id_stall)
        ex_meta_q <= META_BUBBLE;
      else
        ex_meta_q <= id_meta_i;
    end
  end

  // EX/MEM
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      mem_meta_q <= META_BUBBLE;
    else if (!ctrl_i.mem_stall)
    begin
      if (ctrl_i.ex_stall)
        mem_meta_q <= META_BUBBLE;
      else
        mem_meta_q <= ex_meta_q;
    end
  end

  // MEM/WB, nothing holds here
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      wb_meta_q <= META_BUBBLE;
    else if (ctrl_i.mem_stall)
      wb_meta_q <= META_BUBBLE;
    else
      wb_meta_q <= mem_meta_q;
  end

  assign id_instr_o = id_instr_q;
  assign id_valid_o = id_valid_q;
  assign ex_meta_o  = ex_meta_q;
  assign mem_meta_o = mem_meta_q;
  assign wb_meta_o  = wb_meta_q;

  // empty stages carry no stale fields into the hazard compares
  a_ex_bubble_clean : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !ex_meta_q.valid |-> (ex_meta_q == META_BUBBLE)
  );

  a_mem_bubble_clean : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !mem_meta_q.valid |-> (mem_meta_q == META_BUBBLE)
  );

  a_wb_bubble_clean : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !wb_meta_q.valid |-> (wb_meta_q == META_BUBBLE)
  );

endmodule

/* rtl/dtcore32_pipe_ctrl_top.sv */
`timescale 1ns/1ps

module dtcore32_pipe_ctrl_top
  import dtcore32_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic            instr_valid_i,
  input  logic            branch_taken_i,
  output hazard_ctrl_t    hazard_o,
  output stage_meta_t     wb_meta_o
);

  instr_u      id_instr;
  logic        id_valid;
  stage_meta_t id_meta;
  stage_meta_t ex_meta;
  stage_meta_t mem_meta;

  dtcore32_stage_regs stage_regs_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .ctrl_i        (hazard_o),
    .id_meta_i     (id_meta),
    .id_instr_o    (id_instr),
    .id_valid_o    (id_valid),
    .ex_meta_o     (ex_meta),
    .mem_meta_o    (mem_meta),
    .wb_meta_o     (wb_meta_o)
  );

  // decode sits between IF/ID and ID/EX
  dtcore32_decode_fields decode_fields_inst (
    .instr_i (id_instr),
    .valid_i (id_valid),
    .meta_o  (id_meta)
  );

  // branch_taken_i is qualified with the EX valid bit inside
  dtcore32_hazard_unit hazard_unit_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .id_meta_i  (id_meta),
    .ex_meta_i  (ex_meta),
    .mem_meta_i (mem_meta),
    .wb_meta_i  (wb_meta_o),
    .pc_src_i   (branch_taken_i),
    .ctrl_o     (hazard_o)
  );

endmodule

/* tests/tb_dtcore32_pipe_ctrl.sv */
`timescale 1ns/1ps

module tb_dtcore32_pipe_ctrl
  import dtcore32_pkg::*;
();

  localparam int    CLK_PERIOD    = 100;
  localparam int    DRIVE_DELAY   = 1;
  localparam int    RESET_CYCLES  = 5;
  localparam int    RESET_TIMEOUT = 20;
  localparam string DATA_FILE     = "tests/dtcore32_testdata.txt";

  // one line of the data file
  typedef struct packed {
    logic [7:0]            test_id;
    logic [XLEN-1:0]       instr;
    logic                  instr_valid;
    logic                  branch_taken;
    hazard_ctrl_t          exp_hazard;
    logic                  exp_wb_valid;
    logic [REG_ADDR_W-1:0] exp_wb_dest;
    logic                  exp_wb_wr_en;
    logic                  exp_wb_trap;
  } vector_t;

  logic            clk_i;
  logic            rst_i;
  logic [XLEN-1:0] instr_i;
  logic            instr_valid_i;
  logic            branch_taken_i;
  hazard_ctrl_t    hazard_o;
  stage_meta_t     wb_meta_o;

  vector_t vectors[$];
  int      check_count;
  int      error_count;
  int      other_failures;
  int      test_errors;
  int      tests_done;
  int      cur_test;
  int      cur_vec;

  dtcore32_pipe_ctrl_top dtcore32_pipe_ctrl_top_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_i        (instr_i),
    .instr_valid_i  (instr_valid_i),
    .branch_taken_i (branch_taken_i),
    .hazard_o       (hazard_o),
    .wb_meta_o      (wb_meta_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic string test_name(input int id);
    case (id)
      1: return "reset state";
      2: return "forwarding";
      3: return "load stalls";
      4: return "branch flush";
      5: return "trap flush";
      6: return "in-order retire";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      test_errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h (test %0d, vector %0d)",
               name, actual, expected, cur_test, cur_vec);
    end
  endtask

  // lines starting with # are column notes
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_test, f_instr, f_valid, f_branch, f_fwd_a, f_fwd_b;
    logic [31:0] f_if_st, f_id_st, f_ex_st, f_mem_st, f_id_fl, f_ex_fl;
    logic [31:0] f_wb_valid, f_wb_dest, f_wb_wr, f_wb_trap;
    vector_t     vec;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0)
    begin
      $display("could not open the stimulus file %s", DATA_FILE);
      other_failures++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if ((n > 0) && (line.len() > 0) && (line[0] != "#"))
        begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f_test, f_instr, f_valid, f_branch, f_fwd_a, f_fwd_b,
                      f_if_st, f_id_st, f_ex_st, f_mem_st, f_id_fl, f_ex_fl,
                      f_wb_valid, f_wb_dest, f_wb_wr, f_wb_trap);
          if (n == 16)
          begin
            vec.test_id              = f_test[7:0];
            vec.instr                = f_instr;
            vec.instr_valid          = f_valid[0];
            vec.branch_taken         = f_branch[0];
            vec.exp_hazard.fwd_a     = fwd_sel_e'(f_fwd_a[1:0]);
            vec.exp_hazard.fwd_b     = fwd_sel_e'(f_fwd_b[1:0]);
            vec.exp_hazard.if_stall  = f_if_st[0];
            vec.exp_hazard.id_stall  = f_id_st[0];
            vec.exp_hazard.ex_stall  = f_ex_st[0];
            vec.exp_hazard.mem_stall = f_mem_st[0];
            vec.exp_hazard.id_flush  = f_id_fl[0];
            vec.exp_hazard.ex_flush  = f_ex_fl[0];
            vec.exp_wb_valid         = f_wb_valid[0];
            vec.exp_wb_dest          = f_wb_dest[REG_ADDR_W-1:0];
            vec.exp_wb_wr_en         = f_wb_wr[0];
            vec.exp_wb_trap          = f_wb_trap[0];
            vectors.push_back(vec);
          end
          else if (n > 0)
          begin
            $display("malformed stimulus line: %s", line);
            other_failures++;
          end
        end
      end
      $fclose(fd);
      if (vectors.size() == 0)
      begin
        $display("no stimulus vectors were read from %s", DATA_FILE);
        other_failures++;
      end
    end
  endtask

  task automatic apply_vector(input vector_t vec);
    instr_i        = vec.instr;
    instr_valid_i  = vec.instr_valid;
    branch_taken_i = vec.branch_taken;
  endtask

  task automatic check_outputs(input vector_t vec);
    check_value("hazard_o.fwd_a", 32'(hazard_o.fwd_a), 32'(vec.exp_hazard.fwd_a));
    check_value("hazard_o.fwd_b", 32'(hazard_o.fwd_b), 32'(vec.exp_hazard.fwd_b));
    check_value("hazard_o.if_stall", 32'(hazard_o.if_stall), 32'(vec.exp_hazard.if_stall));
    check_value("hazard_o.id_stall", 32'(hazard_o.id_stall), 32'(vec.exp_hazard.id_stall));
    check_value("hazard_o.ex_stall", 32'(hazard_o.ex_stall), 32'(vec.exp_hazard.ex_stall));
    check_value("hazard_o.mem_stall", 32'(hazard_o.mem_stall), 32'(vec.exp_hazard.mem_stall));
    check_value("hazard_o.id_flush", 32'(hazard_o.id_flush), 32'(vec.exp_hazard.id_flush));
    check_value("hazard_o.ex_flush", 32'(hazard_o.ex_flush), 32'(vec.exp_hazard.ex_flush));
    check_value("wb_meta_o.valid", 32'(wb_meta_o.valid), 32'(vec.exp_wb_valid));
    check_value("wb_meta_o.dest", 32'(wb_meta_o.dest), 32'(vec.exp_wb_dest));
    check_value("wb_meta_o.reg_wr_en", 32'(wb_meta_o.reg_wr_en), 32'(vec.exp_wb_wr_en));
    check_value("wb_meta_o.trap_valid", 32'(wb_meta_o.trap_valid), 32'(vec.exp_wb_trap));
  endtask

  // pipeline must show bubbles everywhere before stimulus starts
  task automatic wait_reset_release(output logic ok);
    int cycles;
    cycles = 0;
    while (((hazard_o !== '0) || (wb_meta_o.valid !== 1'b0)) && (cycles < RESET_TIMEOUT))
    begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      cycles++;
    end
    ok = (cycles < RESET_TIMEOUT);
    if (!ok)
    begin
      $display("pipeline did not reach its reset state within %0d cycles", RESET_TIMEOUT);
      other_failures++;
    end
  endtask

  // drive just after the edge, sample 1 ns before the next one
  task automatic run_vectors();
    int vec_in_test;
    vec_in_test = 0;
    for (int i = 0; i < vectors.size(); i++)
    begin
      cur_vec  = i;
      cur_test = int'(vectors[i].test_id);
      apply_vector(vectors[i]);
      #(CLK_PERIOD - DRIVE_DELAY - 1);
      check_outputs(vectors[i]);
      vec_in_test++;
      if ((i == vectors.size() - 1) || (vectors[i + 1].test_id != vectors[i].test_id))
      begin
        $display("test %0d (%s): %0d vectors, %0d mismatches",
                 cur_test, test_name(cur_test), vec_in_test, test_errors);
        tests_done++;
        vec_in_test = 0;
        test_errors = 0;
      end
      @(posedge clk_i);
      #(DRIVE_DELAY);
    end
  endtask

  initial
  begin
    logic reset_ok;
    rst_i          = 1'b1;
    instr_i        = '0;
    instr_valid_i  = 1'b0;
    branch_taken_i = 1'b0;
    check_count    = 0;
    error_count    = 0;
    other_failures = 0;
    test_errors    = 0;
    tests_done     = 0;
    cur_test       = 0;
    cur_vec        = 0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_i = 1'b0;
    wait_reset_release(reset_ok);
    if (reset_ok && (other_failures == 0))
      run_vectors();
    $display("summary: %0d tests, %0d vectors, %0d checks, %0d mismatches, %0d other failures",
             tests_done, vectors.size(), check_count, error_count, other_failures);
    if ((error_count == 0) && (other_failures == 0))
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* tests/dtcore32_testdata.txt */
# test instr valid branch | fwd_a fwd_b if_st id_st ex_st mem_st id_fl ex_fl | wb: valid dest wr trap
# all fields hex, one line per clock cycle, fwd 0=none 1=wb 2=mem
1 00000000 0 0 0 0 0 0 0 0 0 0 0 00 0 0
1 00000000 0 0 0 0 0 0 0 0 0 0 0 00 0 0
2 003100B3 1 0 0 0 0 0 0 0 0 0 0 00 0 0
2 00508233 1 0 0 0 0 0 0 0 0 0 0 00 0 0
2 00408333 1 0 0 0 0 0 0 0 0 0 0 00 0 0
2 00030333 1 0 2 0 0 0 0 0 0 0 0 00 0 0
2 00030433 1 0 1 2 0 0 0 0 0 0 1 01 1 0
2 00000000 0 0 2 0 0 0 0 0 0 0 1 04 1 0
2 00000000 0 0 2 0 0 0 0 0 0 0 1 06 1 0
2 00000000 0 0 0 0 0 0 0 0 0 0 1 06 1 0
2 00000000 0 0 0 0 0 0 0 0 0 0 1 08 1 0
3 00012483 1 0 0 0 0 0 0 0 0 0 0 00 0 0
3 00148533 1 0 0 0 0 0 0 0 0 0 0 00 0 0
3 000505B3 1 0 0 0 1 1 0 0 0 0 0 00 0 0
3 000505B3 1 0 0 0 1 1 1 1 0 0 0 00 0 0
3 000505B3 1 0 0 0 0 0 0 0 0 0 0 00 0 0
3 00000000 0 0 1 0 0 0 0 0 0 0 1 09 1 0
3 00000000 0 0 2 0 0 0 0 0 0 0 0 00 0 0
3 00000000 0 0 0 0 0 0 0 0 0 0 1 0A 1 0
3 00000000 0 0 0 0 0 0 0 0 0 0 1 0B 1 0
4 00208463 1 0 0 0 0 0 0 0 0 0 0 00 0 0
4 00000633 1 0 0 0 0 0 0 0 0 0 0 00 0 0
4 000006B3 1 1 0 0 0 0 0 0 1 1 0 00 0 0
4 00000733 1 0 0 0 0 0 0 0 0 0 0 00 0 0
4 00000000 0 0 0 0 0 0 0 0 0 0 1 00 0 0
4 00000000 0 0 0 0 0 0 0 0 0 0 0 00 0 0
4 00000000 0 0 0 0 0 0 0 0 0 0 0 00 0 0
4 00000000 0 0 0 0 0 0 0 0 0 0 1 0E 1 0
5 0000007F 1 0 0 0 0 0 0 0 0 0 0 00 0 0
5 000007B3 1 0 0 0 0 0 0 0 0 0 0 00 0 0
5 00000833 1 0 0 0 0 0 0 0 1 0 0 00 0 0
5 00000000 0 0 0 0 0 0 0 0 1 1 0 00 0 0
5 00000000 0 0 0 0 0 0 0 0 1 1 1 00 0 1
5 00000000 0 0 0 0 0 0 0 0 0 0 1 0F 1 0
5 00000000 0 0 0 0 0 0 0 0 0 0 0 00 0 0
6 003108B3 1 0 0 0 0 0 0 0 0 0 0 00 0 0
6 00520913 1 0 0 0 0 0 0 0 0 0 0 00 0 0
6 123459B7 1 0 0 0 0 0 0 0 0 0 0 00 0 0
6 00532023 1 0 0 0 0 0 0 0 0 0 0 00 0 0
6 00208033 1 0 0 0 0 0 0 0 0 0 1 11 1 0
6 00000000 0 0 0 0 0 0 0 0 0 0 1 12 1 0
6 00000000 0 0 0 0 0 0 0 0 0 0 1 13 1 0
6 00000000 0 0 0 0 0 0 0 0 0 0 1 00 0 0
6 00000000 0 0 0 0 0 0 0 0 0 0 1 00 0 0

/* project.f */
rtl/dtcore32_pkg.sv
rtl/dtcore32_decode_fields.sv
rtl/dtcore32_hazard_unit.sv
rtl/dtcore32_stage_regs.sv
rtl/dtcore32_pipe_ctrl_top.sv
tests/tb_dtcore32_pipe_ctrl.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_dtcore32_pipe_ctrl
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
